// File: src/huff_symbol_pkg.sv
// Huffman symbol definitions
// Symbol ids for letters, subtrees and the sort sentinel, letter table
// indices, field widths and the packed table types shared by the RTL
package huff_symbol_pkg;

    localparam int NUM_LEAVES    = 8;            // Letters A B C E I L O V
    localparam int SYM_W         = 4;
    localparam int NUM_SYMS      = 2 ** SYM_W;   // Weight table depth
    localparam int LEAF_WEIGHT_W = 3;
    localparam int NODE_WEIGHT_W = 5;
    localparam int DEPTH_W       = 3;
    localparam int CODE_W        = 8;

    typedef logic [SYM_W-1:0]              sym_id_t;
    typedef logic [$clog2(NUM_LEAVES)-1:0] letter_idx_t;
    typedef logic [NODE_WEIGHT_W-1:0]      node_weight_t;

    localparam node_weight_t MAX_WEIGHT = NODE_WEIGHT_W'(31);

    // ========================================
    // Symbol ids
    // ========================================
    localparam sym_id_t SYM_MAX  = 4'd15;   // Sentinel, always sorts first
    localparam sym_id_t SYM_A    = 4'd14;
    localparam sym_id_t SYM_B    = 4'd13;
    localparam sym_id_t SYM_C    = 4'd12;
    localparam sym_id_t SYM_E    = 4'd11;
    localparam sym_id_t SYM_I    = 4'd10;
    localparam sym_id_t SYM_L    = 4'd9;
    localparam sym_id_t SYM_O    = 4'd8;
    localparam sym_id_t SYM_V    = 4'd7;
    localparam sym_id_t SUBTREE6 = 4'd6;
    localparam sym_id_t SUBTREE5 = 4'd5;
    localparam sym_id_t SUBTREE4 = 4'd4;
    localparam sym_id_t SUBTREE3 = 4'd3;
    localparam sym_id_t SUBTREE2 = 4'd2;
    localparam sym_id_t SUBTREE1 = 4'd1;
    localparam sym_id_t SUBTREE0 = 4'd0;

    // Letter table index, A sits in the top slot
    localparam letter_idx_t IDX_A = 3'd7;
    localparam letter_idx_t IDX_B = 3'd6;
    localparam letter_idx_t IDX_C = 3'd5;
    localparam letter_idx_t IDX_E = 3'd4;
    localparam letter_idx_t IDX_I = 3'd3;
    localparam letter_idx_t IDX_L = 3'd2;
    localparam letter_idx_t IDX_O = 3'd1;
    localparam letter_idx_t IDX_V = 3'd0;

    // Leaf id per letter table index
    localparam sym_id_t LEAF_ID [NUM_LEAVES] = '{
        SYM_V, SYM_O, SYM_L, SYM_I, SYM_E, SYM_C, SYM_B, SYM_A
    };

    // Subtree id handed out by merge step 1 to 7
    localparam sym_id_t SUBTREE_ID [NUM_LEAVES-1] = '{
        SUBTREE6, SUBTREE5, SUBTREE4, SUBTREE3, SUBTREE2, SUBTREE1, SUBTREE0
    };

    typedef logic [NUM_LEAVES-1:0][LEAF_WEIGHT_W-1:0] leaf_weight_vec_t;
    typedef node_weight_t [NUM_LEAVES-1:0]            node_weight_vec_t;
    typedef sym_id_t [NUM_LEAVES-1:0]                 sym_vec_t;
    typedef logic [NUM_LEAVES-1:0][DEPTH_W-1:0]       depth_vec_t;
    typedef logic [NUM_LEAVES-1:0][CODE_W-1:0]        code_vec_t;
    typedef logic [NUM_LEAVES-1:0]                    leaf_mask_t;   // One bit per letter

endpackage

// File: src/huff_ctrl_pkg.sv
// Huffman control definitions
// Burst and merge lengths, counter widths, output word select and the
// letter order of each output word
package huff_ctrl_pkg;

    localparam int BURST_LEN    = 8;   // Weight beats per burst
    localparam int MERGE_STEPS  = 7;
    localparam int WORD_LETTERS = 5;

    localparam int BEAT_W       = $clog2(BURST_LEN);
    localparam int STEP_W       = $clog2(MERGE_STEPS + 1);
    localparam int LETTER_CNT_W = $clog2(WORD_LETTERS);

    typedef enum logic {
        WORD_ILOVE = 1'b0,
        WORD_ICLAB = 1'b1
    } word_sel_t;

    // ========================================
    // Word letter orders
    // ========================================
    localparam huff_symbol_pkg::letter_idx_t ILOVE_ORDER [WORD_LETTERS] = '{
        huff_symbol_pkg::IDX_I, huff_symbol_pkg::IDX_L, huff_symbol_pkg::IDX_O,
        huff_symbol_pkg::IDX_V, huff_symbol_pkg::IDX_E
    };

    localparam huff_symbol_pkg::letter_idx_t ICLAB_ORDER [WORD_LETTERS] = '{
        huff_symbol_pkg::IDX_I, huff_symbol_pkg::IDX_C, huff_symbol_pkg::IDX_L,
        huff_symbol_pkg::IDX_A, huff_symbol_pkg::IDX_B
    };

endpackage

// File: src/symbol_sorter.sv
// Symbol sorter
// Odd-even transposition network over eight id and weight pairs. Orders
// by weight, heaviest first; on equal weight the larger id goes first.
// Pure combinational, only the ordered ids leave
`timescale 1ns/100ps

module symbol_sorter (
    input  huff_symbol_pkg::sym_vec_t         sym_in,
    input  huff_symbol_pkg::node_weight_vec_t wt_in,
    output huff_symbol_pkg::sym_vec_t         sym_out
);
    import huff_symbol_pkg::*;

    // True when pair a belongs ahead of pair b
    function automatic logic goes_first(
        input node_weight_t wt_a,
        input sym_id_t      sym_a,
        input node_weight_t wt_b,
        input sym_id_t      sym_b
    );
        return (wt_a > wt_b) || ((wt_a == wt_b) && (sym_a > sym_b));
    endfunction

    // ========================================
    // Compare-exchange network
    // ========================================
    always_comb begin
        sym_vec_t         sym_work;
        node_weight_vec_t wt_work;

        sym_work = sym_in;
        wt_work  = wt_in;
        // Eight rounds, even pairs then odd pairs in turn
        for (int stage = 0; stage < NUM_LEAVES; stage++) begin
            for (int j = stage % 2; j < NUM_LEAVES - 1; j += 2) begin
                if (!goes_first(wt_work[j], sym_work[j], wt_work[j+1], sym_work[j+1])) begin
                    {sym_work[j], sym_work[j+1]} = {sym_work[j+1], sym_work[j]};
                    {wt_work[j], wt_work[j+1]}   = {wt_work[j+1], wt_work[j]};
                end
            end
        end
        sym_out = sym_work;   // Slot 0 heaviest, last slot lightest
    end

endmodule

// File: src/weight_capture.sv
// Weight capture
// Counts the eight beats of a burst, stores each weight in its letter
// slot, latches the word select on the first beat and starts the build
`timescale 1ns/100ps

module weight_capture (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    input  logic [huff_symbol_pkg::LEAF_WEIGHT_W-1:0] in_weight,
    input  logic                                      out_mode,
    output huff_symbol_pkg::leaf_weight_vec_t         leaf_weights,
    output huff_ctrl_pkg::word_sel_t                  word_sel,
    output logic                                      build_start
);
    import huff_symbol_pkg::*;
    import huff_ctrl_pkg::*;

    logic [BEAT_W-1:0] beat_cnt;
    logic              first_beat;
    logic              last_beat;

    assign first_beat = in_valid && (beat_cnt == '0);
    assign last_beat  = in_valid && (beat_cnt == BEAT_W'(BURST_LEN - 1));

    // ========================================
    // Burst control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt    <= '0;
            word_sel    <= WORD_ILOVE;
            build_start <= 1'b0;
        end else begin
            build_start <= last_beat;   // One cycle after the eighth beat
            if (in_valid) begin
                beat_cnt <= beat_cnt + BEAT_W'(1);   // Wraps to 0 after beat 8
            end else begin
                beat_cnt <= '0;
            end
            if (first_beat) begin
                word_sel <= word_sel_t'(out_mode);   // Later beats do not matter
            end
        end
    end

    // Weights arrive A first, and A owns the top slot
    always_ff @(posedge clk) begin
        if (in_valid) begin
            leaf_weights[NUM_LEAVES - 1 - beat_cnt] <= in_weight;
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_start_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        build_start |=> !build_start
    ) else $error("build_start held for more than one cycle");

endmodule

// File: src/huff_tree_builder.sv
// Huffman tree builder
// Loads the eight leaves, then runs seven merge steps. Each step joins the
// two lightest nodes from the sorting network into a new subtree and
// extends the code and depth of every letter below them
`timescale 1ns/100ps

module huff_tree_builder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              build_start,
    input  huff_symbol_pkg::leaf_weight_vec_t leaf_weights,
    output huff_symbol_pkg::code_vec_t        code_table,
    output huff_symbol_pkg::depth_vec_t       depth_table,
    output logic                              tree_done
);
    import huff_symbol_pkg::*;
    import huff_ctrl_pkg::*;

    // Sort registers feeding the network
    sym_vec_t          sort_sym;
    node_weight_vec_t  sort_wt;
    sym_vec_t          sorted_sym;

    // Tables indexed by symbol id
    node_weight_t      wt_table   [NUM_SYMS];
    leaf_mask_t        mask_table [NUM_SYMS-1];   // Sentinel has no entry

    logic [STEP_W-1:0] step_cnt;
    logic              merging;

    sym_id_t           lo0_id;     // Second to last, takes bit 0
    sym_id_t           lo1_id;     // Last, takes bit 1
    sym_id_t           new_id;
    leaf_mask_t        lo0_mask;
    leaf_mask_t        lo1_mask;
    logic [NODE_WEIGHT_W:0] wt_sum;
    node_weight_t      new_wt;

    symbol_sorter u_sorter (
        .sym_in  (sort_sym),
        .wt_in   (sort_wt),
        .sym_out (sorted_sym)
    );

    // ========================================
    // Merge of the two lightest nodes
    // ========================================
    assign lo0_id   = sorted_sym[NUM_LEAVES-2];
    assign lo1_id   = sorted_sym[NUM_LEAVES-1];
    assign lo0_mask = mask_table[lo0_id];
    assign lo1_mask = mask_table[lo1_id];
    assign new_id   = SUBTREE_ID[step_cnt - STEP_W'(1)];

    assign wt_sum = {1'b0, wt_table[lo0_id]} + {1'b0, wt_table[lo1_id]};
    // Only one node can pass 31, so saturating keeps the order intact
    assign new_wt = wt_sum[NODE_WEIGHT_W] ? MAX_WEIGHT : wt_sum[NODE_WEIGHT_W-1:0];

    assign merging   = (step_cnt != '0);
    assign tree_done = (step_cnt == STEP_W'(MERGE_STEPS));

    // Step counter, 1 to 7 while merging
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (build_start) begin
            step_cnt <= STEP_W'(1);
        end else if (tree_done) begin
            step_cnt <= '0;
        end else if (merging) begin
            step_cnt <= step_cnt + STEP_W'(1);
        end
    end

    // ========================================
    // Sort registers and tables
    // ========================================
    always_ff @(posedge clk) begin
        if (build_start) begin
            for (int i = 0; i < NUM_LEAVES; i++) begin
                sort_sym[i]            <= LEAF_ID[i];
                sort_wt[i]             <= NODE_WEIGHT_W'(leaf_weights[i]);
                wt_table[LEAF_ID[i]]   <= NODE_WEIGHT_W'(leaf_weights[i]);
                mask_table[LEAF_ID[i]] <= leaf_mask_t'(1) << i;
            end
            wt_table[SYM_MAX] <= MAX_WEIGHT;
            code_table        <= '0;
            depth_table       <= '0;
        end else if (merging) begin
            // Sentinel refills slot 0, the new subtree takes the last slot
            sort_sym[0] <= SYM_MAX;
            sort_wt[0]  <= MAX_WEIGHT;
            for (int i = 1; i < NUM_LEAVES - 1; i++) begin
                sort_sym[i] <= sorted_sym[i-1];
                sort_wt[i]  <= wt_table[sorted_sym[i-1]];
            end
            sort_sym[NUM_LEAVES-1] <= new_id;
            sort_wt[NUM_LEAVES-1]  <= new_wt;

            wt_table[new_id]   <= new_wt;
            mask_table[new_id] <= lo0_mask | lo1_mask;

            // New bit enters at bit 0, so the root bit ends up in bit 0
            for (int i = 0; i < NUM_LEAVES; i++) begin
                if (lo0_mask[i]) begin
                    code_table[i]  <= {code_table[i][CODE_W-2:0], 1'b0};
                    depth_table[i] <= depth_table[i] + DEPTH_W'(1);
                end else if (lo1_mask[i]) begin
                    code_table[i]  <= {code_table[i][CODE_W-2:0], 1'b1};
                    depth_table[i] <= depth_table[i] + DEPTH_W'(1);
                end
            end
        end
    end

    // ========================================
    // Checks
    // ========================================
    // Counter tops out at MERGE_STEPS on the last step and then returns to idle
    a_step_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        build_start |-> ##MERGE_STEPS (tree_done && step_cnt == STEP_W'(MERGE_STEPS))
                        ##1 (step_cnt == '0)
    ) else $error("merge step counter passed MERGE_STEPS or missed tree_done");

endmodule

// File: src/code_serializer.sv
// Code serializer
// After the tree is done, walks the five letters of the selected word and
// shifts out each code from bit 0 up to depth-1, one bit per cycle
`timescale 1ns/100ps

module code_serializer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tree_done,
    input  huff_ctrl_pkg::word_sel_t    word_sel,
    input  huff_symbol_pkg::code_vec_t  code_table,
    input  huff_symbol_pkg::depth_vec_t depth_table,
    output logic                        out_valid,
    output logic                        out_code
);
    import huff_symbol_pkg::*;
    import huff_ctrl_pkg::*;

    logic                    busy;
    logic [LETTER_CNT_W-1:0] letter_cnt;
    logic [DEPTH_W-1:0]      bit_cnt;

    letter_idx_t             cur_idx;
    logic [DEPTH_W-1:0]      cur_depth;
    logic [CODE_W-1:0]       cur_code;
    logic                    last_bit;
    logic                    last_letter;

    // ========================================
    // Current letter
    // ========================================
    always_comb begin
        if (word_sel == WORD_ICLAB) begin
            cur_idx = ICLAB_ORDER[letter_cnt];
        end else begin
            cur_idx = ILOVE_ORDER[letter_cnt];
        end
    end

    assign cur_depth   = depth_table[cur_idx];
    assign cur_code    = code_table[cur_idx];
    assign last_bit    = (bit_cnt == cur_depth - DEPTH_W'(1));
    assign last_letter = (letter_cnt == LETTER_CNT_W'(WORD_LETTERS - 1));

    // ========================================
    // Letter and bit walk
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            letter_cnt <= '0;
            bit_cnt    <= '0;
        end else if (tree_done) begin
            busy       <= 1'b1;   // Tables settle on this same edge
            letter_cnt <= '0;
            bit_cnt    <= '0;
        end else if (busy) begin
            if (last_bit) begin
                bit_cnt <= '0;
                if (last_letter) begin
                    busy <= 1'b0;
                end else begin
                    letter_cnt <= letter_cnt + LETTER_CNT_W'(1);
                end
            end else begin
                bit_cnt <= bit_cnt + DEPTH_W'(1);
            end
        end
    end

    assign out_valid = busy;
    assign out_code  = busy & cur_code[bit_cnt];   // Root side bit first

    // ========================================
    // Checks
    // ========================================
    a_code_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> !out_code
    ) else $error("out_code high while out_valid is low");

endmodule

// File: src/huff_top.sv
// Huffman encoder top level
// Captures a burst of eight letter weights, builds the code tree and
// streams the codes of ILOVE or ICLAB one bit per cycle
`timescale 1ns/100ps

module huff_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    input  logic [huff_symbol_pkg::LEAF_WEIGHT_W-1:0] in_weight,
    input  logic                                      out_mode,
    output logic                                      out_valid,
    output logic                                      out_code
);
    import huff_symbol_pkg::*;
    import huff_ctrl_pkg::*;

    leaf_weight_vec_t leaf_weights;
    word_sel_t        word_sel;
    logic             build_start;
    code_vec_t        code_table;
    depth_vec_t       depth_table;
    logic             tree_done;

    // Input side
    weight_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_weight    (in_weight),
        .out_mode     (out_mode),
        .leaf_weights (leaf_weights),
        .word_sel     (word_sel),
        .build_start  (build_start)
    );

    // Tree build, seven merges
    huff_tree_builder u_builder (
        .clk          (clk),
        .rst_n        (rst_n),
        .build_start  (build_start),
        .leaf_weights (leaf_weights),
        .code_table   (code_table),
        .depth_table  (depth_table),
        .tree_done    (tree_done)
    );

    // Output side
    code_serializer u_serializer (
        .clk          (clk),
        .rst_n        (rst_n),
        .tree_done    (tree_done),
        .word_sel     (word_sel),
        .code_table   (code_table),
        .depth_table  (depth_table),
        .out_valid    (out_valid),
        .out_code     (out_code)
    );

endmodule

// File: dv/huff_tb.sv
// Huffman encoder testbench
// Directed tests against a reference Huffman model: reset state, the
// ILOVE and ICLAB words, random bursts and first-beat mode capture
`timescale 1ns/100ps

module huff_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 20;
    localparam int NUM_BURSTS     = 24;   // 1 + 1 + 20 + 2
    localparam int TIMEOUT_CYCLES = NUM_BURSTS * 60 + RESET_CYCLES + IDLE_CYCLES;
    localparam int RISE_CYCLE     = 9;    // out_valid rises at L+9
    localparam int RISE_LIMIT     = 20;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [2:0] in_weight;
    logic       out_mode;
    logic       out_valid;
    logic       out_code;

    logic [2:0]  burst_w [8];             // Beats in send order with A first
    int          ref_code [8];            // Indexed by letter with V at 0
    int          ref_depth [8];
    logic [31:0] lfsr_state  = 32'h6270f161;
    int          error_count = 0;
    int          cycle_cnt   = 0;

    huff_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_weight (in_weight),
        .out_mode  (out_mode),
        .out_valid (out_valid),
        .out_code  (out_code)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "Timeout");
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // Letter index at position pos of the selected word
    function automatic int word_letter(input logic mode, input int pos);
        int ilove [5];
        int iclab [5];
        ilove = '{3, 2, 1, 0, 4};   // I L O V E
        iclab = '{3, 5, 2, 7, 6};   // I C L A B
        return mode ? iclab[pos] : ilove[pos];
    endfunction

    // Reference model that sorts only the live nodes
    task automatic compute_model();
        int nid [8];
        int nwt [8];
        int nmask [8];
        int n;
        int t;
        for (int i = 0; i < 8; i++) begin
            ref_code[i]  = 0;
            ref_depth[i] = 0;
            nid[i]       = i + 7;         // V=7 up to A=14
            nwt[i]       = burst_w[7 - i];
            nmask[i]     = 1 << i;
        end
        n = 8;
        for (int step = 0; step < 7; step++) begin
            // Heaviest first and larger id first on a tie
            for (int a = 0; a < n - 1; a++) begin
                for (int j = 0; j < n - 1 - a; j++) begin
                    if ((nwt[j+1] > nwt[j]) ||
                        ((nwt[j+1] == nwt[j]) && (nid[j+1] > nid[j]))) begin
                        t          = nid[j];
                        nid[j]     = nid[j+1];
                        nid[j+1]   = t;
                        t          = nwt[j];
                        nwt[j]     = nwt[j+1];
                        nwt[j+1]   = t;
                        t          = nmask[j];
                        nmask[j]   = nmask[j+1];
                        nmask[j+1] = t;
                    end
                end
            end
            for (int i = 0; i < 8; i++) begin
                if (nmask[n-2][i]) begin
                    ref_code[i]  = ref_code[i] << 1;
                    ref_depth[i] = ref_depth[i] + 1;
                end else if (nmask[n-1][i]) begin
                    ref_code[i]  = (ref_code[i] << 1) | 1;
                    ref_depth[i] = ref_depth[i] + 1;
                end
            end
            nid[n-2]   = 6 - step;   // Next lower subtree id
            nwt[n-2]   = nwt[n-2] + nwt[n-1];
            nmask[n-2] = nmask[n-2] | nmask[n-1];
            n = n - 1;
        end
    endtask

    task automatic send_burst(input logic mode, input logic toggle_rest);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            in_weight <= burst_w[i];
            out_mode  <= (i == 0 || !toggle_rest) ? mode : ~mode;
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        in_weight <= '0;
    endtask

    // Called right after send_burst, so negedge n lies in cycle L+n
    task automatic expect_word(input string name, input logic mode);
        int          rise_cycle;
        int          nbits;
        int          exp_len;
        int          idx;
        logic [63:0] act_stream;
        logic [63:0] exp_stream;
        compute_model();
        exp_stream = '0;
        exp_len    = 0;
        for (int p = 0; p < 5; p++) begin
            idx = word_letter(mode, p);
            for (int b = 0; b < ref_depth[idx]; b++) begin
                exp_stream[exp_len] = ref_code[idx][b];   // Root side bit first
                exp_len++;
            end
        end
        rise_cycle = 0;
        for (int n = 1; n <= RISE_LIMIT && rise_cycle == 0; n++) begin
            @(negedge clk);
            if (out_valid) rise_cycle = n;
        end
        check_value({name, " rise cycle"}, RISE_CYCLE, rise_cycle);
        act_stream = '0;
        nbits      = 0;
        while (out_valid && nbits < 64) begin
            act_stream[nbits] = out_code;
            nbits++;
            @(negedge clk);
        end
        check_value({name, " length"}, exp_len, nbits);
        check_value({name, " stream"}, exp_stream, act_stream);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_reset_idle();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("reset out_valid", 0, out_valid);
            check_value("reset out_code", 0, out_code);
        end
    endtask

    task automatic test_ilove();
        for (int i = 0; i < 8; i++) burst_w[i] = 3'(7 - i);
        send_burst(1'b0, 1'b0);
        expect_word("ilove", 1'b0);
    endtask

    task automatic test_iclab_ties();
        for (int i = 0; i < 8; i++) burst_w[i] = 3'd5;   // Every node ties
        send_burst(1'b1, 1'b0);
        expect_word("iclab ties", 1'b1);
    endtask

    task automatic fill_random();
        logic [2:0] w;
        for (int i = 0; i < 8; i++) begin
            w = '0;
            for (int b = 0; b < 3; b++) w = {w[1:0], next_rand_bit()};
            burst_w[i] = w;
        end
    endtask

    task automatic test_random_bursts();
        logic mode;
        for (int k = 0; k < 20; k++) begin
            mode = k[0];
            fill_random();
            send_burst(mode, 1'b0);
            expect_word($sformatf("random %0d", k), mode);
        end
    endtask

    // Mode flips on beats 2 to 8 must not reach the word select
    task automatic test_mode_isolation();
        fill_random();
        send_burst(1'b0, 1'b1);
        expect_word("isolation first", 1'b0);
        fill_random();
        send_burst(1'b1, 1'b1);
        expect_word("isolation second", 1'b1);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_weight = '0;
        out_mode  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_idle();
        test_ilove();
        test_iclab_ties();
        test_random_bursts();
        test_mode_isolation();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
src/huff_symbol_pkg.sv
src/huff_ctrl_pkg.sv
src/symbol_sorter.sv
src/weight_capture.sv
src/huff_tree_builder.sv
src/code_serializer.sv
src/huff_top.sv
dv/huff_tb.sv
